// File: files.f
source/cachePkg.sv
source/cacheSram.sv
source/sramArbiter.sv
source/lineCopyEngine.sv
source/cacheController.sv
source/cacheTop.sv
verification/extMemModel.sv
verification/cacheTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cacheTb -f files.f -o cacheSim

out=$(./obj_dir/cacheSim)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS"

// File: verification/cacheTb.sv
module cacheTb
    import cachePkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam wordT fillPattern = 32'h3c5a_96e1;
    localparam int   stallLimit  = 2000;
    localparam int   fenceLimit  = 20000;
    localparam wordT opClean     = 32'd0;
    localparam wordT opInval     = 32'd1;
    localparam wordT opFlush     = 32'd2;

    logic        clk;
    logic        rst;
    logic        ldValid;
    addrT        ldAddr;
    logic        ldStall;
    logic        ldDataValid;
    wordT        ldData;
    logic        stValid;
    addrT        stAddr;
    wordT        stData;
    maskT        stMask;
    logic        stStall;
    logic        fence;
    logic        fenceBusy;
    extWordAddrT extAddr;
    logic        extWe;
    wordT        extWdata;
    wordT        extRdata;

    int   errors;
    int   timeouts;
    int   seed;
    bit   writebackAllowed;
    wordT shadow [int];
    int   touched [$];

    cacheTop DUT (
        .clk         (clk),
        .rst         (rst),
        .ldValid     (ldValid),
        .ldAddr      (ldAddr),
        .ldStall     (ldStall),
        .ldDataValid (ldDataValid),
        .ldData      (ldData),
        .stValid     (stValid),
        .stAddr      (stAddr),
        .stData      (stData),
        .stMask      (stMask),
        .stStall     (stStall),
        .fence       (fence),
        .fenceBusy   (fenceBusy),
        .extAddr     (extAddr),
        .extWe       (extWe),
        .extWdata    (extWdata),
        .extRdata    (extRdata)
    );

    extMemModel #(.fillPattern(fillPattern)) extMem (
        .clk   (clk),
        .addr  (extAddr),
        .we    (extWe),
        .wdata (extWdata),
        .rdata (extRdata)
    );

    always #5 clk = ~clk;

    // Outputs held low while in reset
    resetLow: assert property (@(posedge clk)
        rst |=> !ldStall && !stStall && !ldDataValid && !fenceBusy && !extWe)
    else begin
        errors++;
        $display("Error at %0t ns: reset outputs got %b expected 00000", $time,
                 {$sampled(ldStall), $sampled(stStall), $sampled(ldDataValid),
                  $sampled(fenceBusy), $sampled(extWe)});
    end

    // fenceBusy only rises after a fence strobe
    fenceQuiet: assert property (@(posedge clk)
        !rst && !fence && !fenceBusy |=> !fenceBusy)
    else begin
        errors++;
        $display("Error at %0t ns: fenceBusy got 1 expected 0", $time);
    end

    // No writeback before the first clean
    always @(negedge clk) begin
        if (!rst && !writebackAllowed) begin
            checkValue("extWe", wordT'(extWe), '0);
        end
    end

    task automatic checkValue(input string name, input wordT got, input wordT exp);
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report();
        $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic abortRun(input string what);
        timeouts++;
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        report();
    endtask

    function automatic int wordIndex(input addrT a);
        return int'(a[15:2]);
    endfunction

    function automatic addrT lineAddr(input int line, input int word);
        return addrT'(line * 256 + (word & 63) * 4);
    endfunction

    function automatic wordT expectedWord(input int idx);
        if (shadow.exists(idx)) begin
            return shadow[idx];
        end
        return wordT'(idx) ^ fillPattern;
    endfunction

    task automatic revertLine(input int line);
        for (int w = 0; w < lineWords; w++) begin
            shadow.delete(line * lineWords + w);
        end
    endtask

    task automatic checkExt(input int idx);
        checkValue("extMem.mem", extMem.peek(idx), expectedWord(idx));
    endtask

    task automatic loadWord(input addrT a, output bit missed);
        wordT exp;
        int   cycles;
        exp = expectedWord(wordIndex(a));
        @(posedge clk);
        ldValid <= 1'b1;
        ldAddr  <= a;
        @(negedge clk);
        cycles = 0;
        while (ldStall) begin
            cycles++;
            if (cycles > stallLimit) begin
                abortRun("ldStall to fall before a load");
            end
            @(negedge clk);
        end
        // Accepted on this edge
        @(posedge clk);
        ldValid <= 1'b0;
        @(negedge clk);
        missed = ldStall;
        @(negedge clk);
        if (!missed) begin
            checkValue("ldDataValid", wordT'(ldDataValid), 32'd1);
        end else begin
            cycles = 0;
            while (!ldDataValid) begin
                cycles++;
                if (cycles > stallLimit) begin
                    abortRun("ldDataValid after a load miss");
                end
                @(negedge clk);
            end
        end
        checkValue("ldData", ldData, exp);
    endtask

    task automatic storeWord(input addrT a, input wordT d, input maskT m);
        wordT merged;
        int   cycles;
        @(posedge clk);
        stValid <= 1'b1;
        stAddr  <= a;
        stData  <= d;
        stMask  <= m;
        @(negedge clk);
        cycles = 0;
        while (stStall) begin
            cycles++;
            if (cycles > stallLimit) begin
                abortRun("stStall to fall before a store");
            end
            @(negedge clk);
        end
        @(posedge clk);
        stValid <= 1'b0;
        if (m != '0) begin
            merged = expectedWord(wordIndex(a));
            for (int b = 0; b < 4; b++) begin
                if (m[b]) begin
                    merged[b*8 +: 8] = d[b*8 +: 8];
                end
            end
            shadow[wordIndex(a)] = merged;
            touched.push_back(wordIndex(a));
        end
        // Held miss or management work ends when stStall drops
        @(negedge clk);
        cycles = 0;
        while (stStall) begin
            cycles++;
            if (cycles > stallLimit) begin
                abortRun("stStall to fall after a store");
            end
            @(negedge clk);
        end
    endtask

    initial begin
        bit   missed;
        addrT a;
        wordT d;
        maskT m;
        int   cycles;
        addrT evictAddrs [$];

        clk              = 1'b0;
        rst              = 1'b1;
        ldValid          = 1'b0;
        ldAddr           = '0;
        stValid          = 1'b0;
        stAddr           = '0;
        stData           = '0;
        stMask           = '0;
        fence            = 1'b0;
        errors           = 0;
        timeouts         = 0;
        seed             = 32'he9585f3e;
        writebackAllowed = 1'b0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("ldStall", wordT'(ldStall), '0);
        checkValue("stStall", wordT'(stStall), '0);
        checkValue("ldDataValid", wordT'(ldDataValid), '0);
        checkValue("fenceBusy", wordT'(fenceBusy), '0);
        checkValue("extWe", wordT'(extWe), '0);

        // Cold load misses, second load in the line hits
        for (int l = 0; l < 4; l++) begin
            loadWord(lineAddr(l, $random(seed)), missed);
            checkValue("ldStall after cold load", wordT'(missed), 32'd1);
            loadWord(lineAddr(l, $random(seed)), missed);
            checkValue("ldStall after warm load", wordT'(missed), 32'd0);
        end

        // Masked stores, line 4 starts cold
        for (int k = 0; k < 8; k++) begin
            a = lineAddr(1 + k % 4, $random(seed));
            d = $random(seed);
            m = maskT'($random(seed));
            if (m == '0) begin
                m = 4'b1001;
            end
            storeWord(a, d, m);
            loadWord(a, missed);
            checkValue("ldStall after store", wordT'(missed), 32'd0);
        end

        a = lineAddr(5, $random(seed));
        loadWord(a, missed);
        storeWord(a, $random(seed), 4'b1111);
        storeWord(a, opInval, 4'b0000);
        revertLine(5);
        loadWord(a, missed);
        checkValue("ldStall after invalidate", wordT'(missed), 32'd1);

        writebackAllowed = 1'b1;
        a = lineAddr(6, $random(seed));
        storeWord(a, $random(seed), 4'b0110);
        storeWord(a, opClean, 4'b0000);
        checkExt(wordIndex(a));
        loadWord(a, missed);
        checkValue("ldStall after clean", wordT'(missed), 32'd0);

        a = lineAddr(7, $random(seed));
        storeWord(a, $random(seed), 4'b1111);
        storeWord(a, opFlush, 4'b0000);
        checkExt(wordIndex(a));
        loadWord(a, missed);
        checkValue("ldStall after flush", wordT'(missed), 32'd1);

        // More dirty lines than table entries
        for (int l = 16; l < 36; l++) begin
            a = lineAddr(l, $random(seed));
            evictAddrs.push_back(a);
            storeWord(a, $random(seed), 4'b1111);
        end
        for (int k = 0; k < 4; k++) begin
            loadWord(evictAddrs[k], missed);
        end

        @(posedge clk);
        fence <= 1'b1;
        @(posedge clk);
        fence <= 1'b0;
        @(negedge clk);
        checkValue("fenceBusy", wordT'(fenceBusy), 32'd1);
        cycles = 0;
        while (fenceBusy) begin
            cycles++;
            if (cycles > fenceLimit) begin
                abortRun("fenceBusy to fall");
            end
            @(negedge clk);
        end
        foreach (touched[i]) begin
            checkExt(touched[i]);
        end
        // Table is empty after the fence
        for (int k = 4; k < 8; k++) begin
            loadWord(evictAddrs[k], missed);
            checkValue("ldStall after fence", wordT'(missed), 32'd1);
        end

        report();
    end

endmodule

// File: verification/extMemModel.sv
module extMemModel
    import cachePkg::*;
#(
    parameter wordT fillPattern = 32'h0
)(
    input  logic        clk,
    input  extWordAddrT addr,
    input  logic        we,
    input  wordT        wdata,
    output wordT        rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    // 64 KiB of byte address space
    localparam int memWords = 16384;

    wordT mem [memWords];

    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] = wordT'(i) ^ fillPattern;
        end
    end

    // Read data follows the address by one cycle
    always @(posedge clk) begin
        if (we) begin
            mem[addr[13:0]] <= wdata;
        end
        rdata <= mem[addr[13:0]];
    end

    function automatic wordT peek(input int wordAddr);
        return mem[wordAddr[13:0]];
    endfunction

endmodule

// File: source/cacheTop.sv
module cacheTop
    import cachePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        ldValid,
    input  addrT        ldAddr,
    output logic        ldStall,
    output logic        ldDataValid,
    output wordT        ldData,
    input  logic        stValid,
    input  addrT        stAddr,
    input  wordT        stData,
    input  maskT        stMask,
    output logic        stStall,
    input  logic        fence,
    output logic        fenceBusy,
    output extWordAddrT extAddr,
    output logic        extWe,
    output wordT        extWdata,
    input  wordT        extRdata
);

    copyCmdT  copyCmd;
    lineIdT   copyLine;
    tagT      copyTag;
    logic     copyBusy;

    logic     pipeReq;
    logic     pipeWe;
    sramAddrT pipeAddr;
    wordT     pipeWdata;
    maskT     pipeMask;

    logic     copyReq;
    logic     copyWe;
    sramAddrT copyAddr;
    wordT     copyWdata;
    logic     copyGrant;

    logic     sramEn;
    logic     sramWe;
    maskT     sramMask;
    sramAddrT sramAddr;
    wordT     sramWdata;
    wordT     sramRdata;

    // Load data comes straight off the SRAM read port
    assign ldData = sramRdata;

    cacheController ctrl (
        .clk         (clk),
        .rst         (rst),
        .ldValid     (ldValid),
        .ldAddr      (ldAddr),
        .ldStall     (ldStall),
        .stValid     (stValid),
        .stAddr      (stAddr),
        .stData      (stData),
        .stMask      (stMask),
        .stStall     (stStall),
        .fence       (fence),
        .fenceBusy   (fenceBusy),
        .copyCmd     (copyCmd),
        .copyLine    (copyLine),
        .copyTag     (copyTag),
        .copyBusy    (copyBusy),
        .pipeReq     (pipeReq),
        .pipeWe      (pipeWe),
        .pipeAddr    (pipeAddr),
        .pipeWdata   (pipeWdata),
        .pipeMask    (pipeMask),
        .ldDataValid (ldDataValid)
    );

    sramArbiter arb (
        .pipeReq   (pipeReq),
        .pipeWe    (pipeWe),
        .pipeAddr  (pipeAddr),
        .pipeWdata (pipeWdata),
        .pipeMask  (pipeMask),
        .copyReq   (copyReq),
        .copyWe    (copyWe),
        .copyAddr  (copyAddr),
        .copyWdata (copyWdata),
        .copyGrant (copyGrant),
        .sramEn    (sramEn),
        .sramWe    (sramWe),
        .sramMask  (sramMask),
        .sramAddr  (sramAddr),
        .sramWdata (sramWdata)
    );

    cacheSram sram (
        .clk   (clk),
        .en    (sramEn),
        .we    (sramWe),
        .addr  (sramAddr),
        .wdata (sramWdata),
        .mask  (sramMask),
        .rdata (sramRdata)
    );

    lineCopyEngine copier (
        .clk       (clk),
        .rst       (rst),
        .copyCmd   (copyCmd),
        .copyLine  (copyLine),
        .copyTag   (copyTag),
        .copyBusy  (copyBusy),
        .copyReq   (copyReq),
        .copyWe    (copyWe),
        .copyAddr  (copyAddr),
        .copyWdata (copyWdata),
        .copyGrant (copyGrant),
        .sramRdata (sramRdata),
        .extAddr   (extAddr),
        .extWe     (extWe),
        .extWdata  (extWdata),
        .extRdata  (extRdata)
    );

endmodule

// File: source/cacheController.sv
module cacheController
    import cachePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     ldValid,
    input  addrT     ldAddr,
    output logic     ldStall,
    input  logic     stValid,
    input  addrT     stAddr,
    input  wordT     stData,
    input  maskT     stMask,
    output logic     stStall,
    input  logic     fence,
    output logic     fenceBusy,
    output copyCmdT  copyCmd,
    output lineIdT   copyLine,
    output tagT      copyTag,
    input  logic     copyBusy,
    output logic     pipeReq,
    output logic     pipeWe,
    output sramAddrT pipeAddr,
    output wordT     pipeWdata,
    output maskT     pipeMask,
    output logic     ldDataValid
);

    typedef enum logic [1:0] {mgmtNone, mgmtClean, mgmtInval, mgmtFlush} mgmtT;

    tagT                 tags [numLines];
    logic [numLines-1:0] lineValid;
    logic [numLines-1:0] lineDirty;
    logic [numLines-1:0] lineUsed;

    logic   freeAvail;
    lineIdT freeId;
    lineIdT clockPtr;
    logic   loading;
    logic   evicting;
    logic   evictForMgmt;
    logic   waitCycle;
    mgmtT   mgmtRq;
    lineIdT mgmtId;
    logic   fenceSched;
    logic   fenceActive;

    logic   missLdValid;
    addrT   missLdAddr;
    logic   missStValid;
    addrT   missStAddr;
    wordT   missStData;
    maskT   missStMask;

    addrT   ldLookAddr;
    addrT   stLookAddr;
    wordT   stLookData;
    maskT   stLookMask;
    logic   ldHit;
    logic   stHit;
    lineIdT ldHitId;
    lineIdT stHitId;
    tagT    refillTag;
    logic   ldAccept;
    logic   stAccept;
    logic   ldReplay;
    logic   stReplay;
    logic   pipeIdle;

    function automatic logic [$bits(lineIdT):0] lookup(input tagT tag);
        logic [$bits(lineIdT):0] res;
        res = '0;
        for (int i = 0; i < numLines; i++) begin
            if (lineValid[i] && tags[i] == tag) begin
                res = {1'b1, lineIdT'(i)};
            end
        end
        return res;
    endfunction

    // Held misses take over the lookup until they replay
    always_comb begin
        ldLookAddr = missLdValid ? missLdAddr : ldAddr;
        stLookAddr = missStValid ? missStAddr : stAddr;
        stLookData = missStValid ? missStData : stData;
        stLookMask = missStValid ? missStMask : stMask;
        {ldHit, ldHitId} = lookup(ldLookAddr[31:8]);
        {stHit, stHitId} = lookup(stLookAddr[31:8]);
        refillTag = (missLdValid && !ldHit) ? missLdAddr[31:8] : missStAddr[31:8];
    end

    assign fenceBusy = fenceSched || fenceActive;
    assign ldStall   = missLdValid || waitCycle || fenceSched || fenceActive;
    assign ldAccept  = ldValid && !ldStall;
    assign ldReplay  = missLdValid && ldHit;

    // Loads own the SRAM port whenever they issue
    assign stStall = missStValid || loading || evicting || waitCycle || mgmtRq != mgmtNone
                     || fenceSched || fenceActive || ldAccept || ldReplay;
    assign stAccept = stValid && !stStall;
    assign stReplay = missStValid && stHit && !ldReplay && !ldAccept;
    assign pipeIdle = !ldAccept && !stAccept && !ldReplay && !stReplay;

    always_ff @(posedge clk) begin
        copyCmd     <= copyNone;
        waitCycle   <= 1'b0;
        pipeReq     <= 1'b0;
        ldDataValid <= pipeReq && !pipeWe;

        if (rst) begin
            lineValid   <= '0;
            lineDirty   <= '0;
            lineUsed    <= '0;
            clockPtr    <= '0;
            freeAvail   <= 1'b1;
            freeId      <= '0;
            loading     <= 1'b0;
            evicting    <= 1'b0;
            mgmtRq      <= mgmtNone;
            fenceSched  <= 1'b0;
            fenceActive <= 1'b0;
            missLdValid <= 1'b0;
            missStValid <= 1'b0;
            ldDataValid <= 1'b0;
        end else begin
            // Second chance; during a fence only skip empty entries
            if (fenceActive) begin
                if (!lineValid[clockPtr]) begin
                    clockPtr <= clockPtr + 1'b1;
                end
            end else if (lineValid[clockPtr] && lineUsed[clockPtr]) begin
                lineUsed[clockPtr] <= 1'b0;
                clockPtr <= clockPtr + 1'b1;
            end

            if (loading) begin
                if (!waitCycle && !copyBusy) begin
                    loading <= 1'b0;
                    lineValid[freeId] <= 1'b1;
                    lineUsed[freeId] <= 1'b1;
                    lineDirty[freeId] <= 1'b0;
                end
            end else if (evicting) begin
                if (!waitCycle && !copyBusy) begin
                    if (evictForMgmt) begin
                        mgmtRq <= mgmtNone;
                    end else begin
                        freeAvail <= 1'b1;
                    end
                    evicting <= 1'b0;
                end
            end else if (mgmtRq != mgmtNone) begin
                if (!lineValid[mgmtId]) begin
                    mgmtRq <= mgmtNone;
                end else if (pipeIdle) begin
                    if (mgmtRq == mgmtClean) begin
                        lineDirty[mgmtId] <= 1'b0;
                    end else begin
                        lineValid[mgmtId] <= 1'b0;
                        lineUsed[mgmtId] <= 1'b0;
                    end
                    if (lineDirty[mgmtId] && mgmtRq != mgmtInval) begin
                        copyCmd      <= copyCacheToExt;
                        copyLine     <= mgmtId;
                        copyTag      <= tags[mgmtId];
                        evicting     <= 1'b1;
                        evictForMgmt <= 1'b1;
                        waitCycle    <= 1'b1;
                    end else begin
                        mgmtRq <= mgmtNone;
                    end
                end
            end else if (!freeAvail || fenceActive) begin
                if (!lineValid[clockPtr]) begin
                    freeAvail <= 1'b1;
                    freeId    <= clockPtr;
                end else if ((!lineUsed[clockPtr] || fenceActive) && pipeIdle) begin
                    lineValid[clockPtr] <= 1'b0;
                    lineUsed[clockPtr] <= 1'b0;
                    freeId <= clockPtr;
                    if (lineDirty[clockPtr]) begin
                        copyCmd      <= copyCacheToExt;
                        copyLine     <= clockPtr;
                        copyTag      <= tags[clockPtr];
                        evicting     <= 1'b1;
                        evictForMgmt <= 1'b0;
                        waitCycle    <= 1'b1;
                    end else begin
                        freeAvail <= 1'b1;
                    end
                end
            end else if ((missLdValid && !ldHit) || (missStValid && !stHit)) begin
                // Load misses refill first
                copyCmd      <= copyExtToCache;
                copyLine     <= freeId;
                copyTag      <= refillTag;
                tags[freeId] <= refillTag;
                loading      <= 1'b1;
                freeAvail    <= 1'b0;
                waitCycle    <= 1'b1;
            end

            if (ldAccept && !ldHit) begin
                missLdValid <= 1'b1;
                missLdAddr  <= ldAddr;
            end
            if ((ldAccept && ldHit) || ldReplay) begin
                pipeReq  <= 1'b1;
                pipeWe   <= 1'b0;
                pipeAddr <= {ldHitId, ldLookAddr[7:2]};
                lineUsed[ldHitId] <= 1'b1;
                missLdValid <= 1'b0;
            end

            // Zero mask selects a management operation by data bits
            if (stAccept && stMask == '0) begin
                if (stHit) begin
                    mgmtId <= stHitId;
                    case (stData[1:0])
                        2'd0:    mgmtRq <= mgmtClean;
                        2'd1:    mgmtRq <= mgmtInval;
                        default: mgmtRq <= mgmtFlush;
                    endcase
                end
            end else if (stAccept && !stHit) begin
                missStValid <= 1'b1;
                missStAddr  <= stAddr;
                missStData  <= stData;
                missStMask  <= stMask;
            end else if (stAccept || stReplay) begin
                pipeReq   <= 1'b1;
                pipeWe    <= 1'b1;
                pipeAddr  <= {stHitId, stLookAddr[7:2]};
                pipeWdata <= stLookData;
                pipeMask  <= stLookMask;
                lineUsed[stHitId]  <= 1'b1;
                lineDirty[stHitId] <= 1'b1;
                missStValid <= 1'b0;
            end

            // Fence ends once the table is empty and the last writeback is done
            if (fenceActive && lineValid == '0 && !evicting) begin
                fenceActive <= 1'b0;
            end else if (fenceSched && !loading && !evicting && mgmtRq == mgmtNone
                         && !missLdValid && !missStValid && pipeIdle) begin
                fenceActive <= 1'b1;
                fenceSched  <= 1'b0;
            end else if (fence) begin
                fenceSched <= 1'b1;
            end
        end
    end

endmodule

// File: source/lineCopyEngine.sv
module lineCopyEngine
    import cachePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  copyCmdT     copyCmd,
    input  lineIdT      copyLine,
    input  tagT         copyTag,
    output logic        copyBusy,
    output logic        copyReq,
    output logic        copyWe,
    output sramAddrT    copyAddr,
    output wordT        copyWdata,
    input  logic        copyGrant,
    input  wordT        sramRdata,
    output extWordAddrT extAddr,
    output logic        extWe,
    output wordT        extWdata,
    input  wordT        extRdata
);

    typedef enum logic [1:0] {stateIdle, stateRead, stateWrite} stateT;

    stateT                        state;
    logic                         toExt;
    lineIdT                       line;
    tagT                          tag;
    logic [$clog2(lineWords)-1:0] wordCnt;
    logic                         step;

    assign copyBusy  = state != stateIdle;
    assign copyAddr  = {line, wordCnt};
    assign copyWdata = extRdata;
    assign extAddr   = {tag, wordCnt};
    assign extWdata  = sramRdata;

    // SRAM is the source when writing back, the destination when refilling
    assign copyReq = (state == stateRead && toExt) || (state == stateWrite && !toExt);
    assign copyWe  = !toExt;
    assign extWe   = state == stateWrite && toExt;

    // Held in place while the pipeline owns the SRAM
    assign step = !copyReq || copyGrant;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stateIdle;
        end else begin
            case (state)
                stateIdle: begin
                    if (copyCmd != copyNone) begin
                        toExt   <= copyCmd == copyCacheToExt;
                        line    <= copyLine;
                        tag     <= copyTag;
                        wordCnt <= '0;
                        state   <= stateRead;
                    end
                end
                stateRead: begin
                    if (step) begin
                        state <= stateWrite;
                    end
                end
                stateWrite: begin
                    if (step) begin
                        if (32'(wordCnt) == lineWords - 1) begin
                            state <= stateIdle;
                        end else begin
                            wordCnt <= wordCnt + 1'b1;
                            state   <= stateRead;
                        end
                    end
                end
                default: state <= stateIdle;
            endcase
        end
    end

endmodule

// File: source/sramArbiter.sv
module sramArbiter
    import cachePkg::*;
(
    input  logic     pipeReq,
    input  logic     pipeWe,
    input  sramAddrT pipeAddr,
    input  wordT     pipeWdata,
    input  maskT     pipeMask,
    input  logic     copyReq,
    input  logic     copyWe,
    input  sramAddrT copyAddr,
    input  wordT     copyWdata,
    output logic     copyGrant,
    output logic     sramEn,
    output logic     sramWe,
    output maskT     sramMask,
    output sramAddrT sramAddr,
    output wordT     sramWdata
);

    // Pipeline always wins, copy engine takes idle cycles
    assign copyGrant = copyReq && !pipeReq;
    assign sramEn    = pipeReq || copyReq;

    always_comb begin
        if (pipeReq) begin
            sramWe    = pipeWe;
            sramAddr  = pipeAddr;
            sramWdata = pipeWdata;
            sramMask  = pipeMask;
        end else begin
            sramWe    = copyWe;
            sramAddr  = copyAddr;
            sramWdata = copyWdata;
            // Line copies always move whole words
            sramMask  = '1;
        end
    end

endmodule

// File: source/cacheSram.sv
module cacheSram
    import cachePkg::*;
(
    input  logic     clk,
    input  logic     en,
    input  logic     we,
    input  sramAddrT addr,
    input  wordT     wdata,
    input  maskT     mask,
    output wordT     rdata
);

    wordT mem [sramWords];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int b = 0; b < $bits(maskT); b++) begin
                    if (mask[b]) begin
                        mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
            end else begin
                // Read data valid one cycle later
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: source/cachePkg.sv
package cachePkg;

    // Cache geometry
    localparam int numLines  = 16;
    localparam int lineWords = 64;
    localparam int sramWords = 1024;

    // Byte address and data word
    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;

    // One enable per byte lane
    typedef logic [3:0] maskT;

    // Line tag is address bits 31 down to 8
    typedef logic [23:0] tagT;

    typedef logic [3:0] lineIdT;

    // Line index followed by word-in-line
    typedef logic [9:0] sramAddrT;

    typedef logic [29:0] extWordAddrT;

    // Controller to copy engine
    typedef enum logic [1:0] {
        copyNone,
        copyExtToCache,
        copyCacheToExt
    } copyCmdT;

endpackage
